//--- Makefile
VERILATOR  ?= verilator
TOP        := simd_exec_tb
FILELIST   := simd_exec.f
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TB FAILED
PASS_MSG   := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- functional_unit.sv
/* One 64-bit SIMD lane: arithmetic blocks, multiplier and the
   two-stage result selector */
`timescale 1ns/1ps

module functional_unit
    import simd_pkg::*;
#(
    parameter int FU_ID = 0
)
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  simd_op_t op_i,                  // Current instruction
    input  sew_t     sew_i,
    input  simd_op_t sel_op_i,              // Instruction one cycle older
    input  sew_t     sel_sew_i,
    input  lane_t    vs1_i,
    input  lane_t    vs2_i,
    output lane_t    vd_o
);

    lane_t       result_vaddsub;
    lane_t       result_vcomp;
    lane_t       result_vshift;
    lane_t       result_vmul;
    lane_t       stage1_d;
    lane_t       stage1_q;
    lane_t       stage2_q;
    logic        mul_sel_q;
    lane_t [3:0] vid_all;

    vaddsub u_vaddsub (
        .op_i  (op_i),
        .sew_i (sew_i),
        .vs1_i (vs1_i),
        .vs2_i (vs2_i),
        .vd_o  (result_vaddsub)
    );

    vcomp u_vcomp (
        .op_i  (op_i),
        .sew_i (sew_i),
        .vs1_i (vs1_i),
        .vs2_i (vs2_i),
        .vd_o  (result_vcomp)
    );

    vshift u_vshift (
        .op_i  (op_i),
        .sew_i (sew_i),
        .vs1_i (vs1_i),
        .vs2_i (vs2_i),
        .vd_o  (result_vshift)
    );

    vmul u_vmul (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .op_i  (op_i),
        .sew_i (sew_i),
        .vs1_i (vs1_i),
        .vs2_i (vs2_i),
        .vd_o  (result_vmul)
    );

    // Element index pattern, FU_ID * elements per lane + position
    for (genvar s = 0; s < 4; s++) begin : g_vid
        localparam int W = 8 << s;
        for (genvar i = 0; i < 64 / W; i++) begin : g_elem
            localparam lane_t IDX = lane_t'(FU_ID * (64 / W) + i);
            assign vid_all[s][i*W +: W] = IDX[W-1:0];
        end
    end

    always_comb begin
        case (op_i)
            VADD, VSUB, VRSUB, VSADDU, VSADD, VSSUBU, VSSUB: stage1_d = result_vaddsub;
            VMIN, VMINU, VMAX, VMAXU, VMSEQ, VMSNE, VMSLT, VMSLTU: stage1_d = result_vcomp;
            VSLL, VSRL, VSRA: stage1_d = result_vshift;
            VAND:    stage1_d = vs1_i & vs2_i;
            VOR:     stage1_d = vs1_i | vs2_i;
            VXOR:    stage1_d = vs1_i ^ vs2_i;
            VMV:     stage1_d = vs1_i;
            default: stage1_d = '0;         // VNOP, and the stage-2 ops
        endcase
    end

    always_ff @(posedge clk_i) begin
        stage1_q <= stage1_d;
        // VID is filled in here, using the width that came with the op
        stage2_q <= (sel_op_i == VID) ? vid_all[sel_sew_i] : stage1_q;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_sel_q <= 1'b0;
        end else begin
            mul_sel_q <= (sel_op_i == VMUL) || (sel_op_i == VMULH);
        end
    end

    assign vd_o = mul_sel_q ? result_vmul : stage2_q;

endmodule

//--- simd_exec.f
simd_pkg.sv
vaddsub.sv
vcomp.sv
vshift.sv
vmul.sv
functional_unit.sv
simd_exec.sv
simd_exec_props.sv
simd_exec_tb.sv

//--- simd_exec.sv
/* SIMD execution slice top: NUM_LANES functional units, the delayed
   op and width register and the issue valid pipeline */
`timescale 1ns/1ps

module simd_exec
    import simd_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  simd_op_t                op_i,
    input  sew_t                    sew_i,
    input  logic [NUM_LANES*64-1:0] vs1_i,
    input  logic [NUM_LANES*64-1:0] vs2_i,
    output logic                    valid_o,
    output logic [NUM_LANES*64-1:0] vd_o
);

    simd_op_t                sel_op_q;
    sew_t                    sel_sew_q;
    logic [MUL_LATENCY-1:0]  valid_q;
    logic [NUM_LANES*64-1:0] fu_vd;
    logic [NUM_LANES*64-1:0] hold_q;        // Last delivered result

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sel_op_q  <= VNOP;
            sel_sew_q <= SEW_8;
            valid_q   <= '0;
            hold_q    <= '0;
        end else begin
            sel_op_q  <= op_i;
            sel_sew_q <= sew_i;
            valid_q   <= {valid_q[MUL_LATENCY-2:0], valid_i};
            if (valid_o) begin
                hold_q <= fu_vd;
            end
        end
    end

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        functional_unit #(
            .FU_ID (l)
        ) u_fu (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .op_i      (op_i),
            .sew_i     (sew_i),
            .sel_op_i  (sel_op_q),
            .sel_sew_i (sel_sew_q),
            .vs1_i     (vs1_i[l*64 +: 64]),
            .vs2_i     (vs2_i[l*64 +: 64]),
            .vd_o      (fu_vd[l*64 +: 64])
        );
    end

    assign valid_o = valid_q[MUL_LATENCY-1];
    assign vd_o    = valid_o ? fu_vd : hold_q;  // Output holds between results

endmodule

//--- simd_exec_props.sv
/* Bound checks on the SIMD slice outputs: reset state, two-cycle
   valid delay and result hold between valid cycles */
`timescale 1ns/1ps

module simd_exec_props #(
    parameter int NUM_LANES = 4
)
(
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    valid_i,
    input logic                    valid_out_i,     // DUT valid_o
    input logic [NUM_LANES*64-1:0] vd_out_i         // DUT vd_o
);

    logic out_seen_q;                               // A result has been delivered
    int   fail_count;                               // Failed assertion count

    initial fail_count = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_seen_q <= 1'b0;
        end else if (valid_out_i) begin
            out_seen_q <= 1'b1;
        end
    end

    a_reset_clear: assert property (@(posedge clk_i)
        rst_i |=> (!valid_out_i && vd_out_i == '0))
        else begin
            fail_count = fail_count + 1;
            $error("valid_o or vd_o not cleared by reset");
        end

    a_quiet_start: assert property (@(posedge clk_i) disable iff (rst_i)
        (!out_seen_q && !valid_out_i) |-> vd_out_i == '0)
        else begin
            fail_count = fail_count + 1;
            $error("vd_o nonzero before the first result");
        end

    // Fixed latency, one result per issue
    a_valid_delay: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_out_i == $past(valid_i, 2))
        else begin
            fail_count = fail_count + 1;
            $error("valid_o is not valid_i delayed by two cycles");
        end

    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        !valid_out_i |-> $stable(vd_out_i))
        else begin
            fail_count = fail_count + 1;
            $error("vd_o changed while valid_o was low");
        end

endmodule

//--- simd_exec_tb.sv
/* Testbench for the SIMD slice: LFSR stimulus, reference model,
   expected-result queue and the output check assertion */
`timescale 1ns/1ps

module simd_exec_tb
    import simd_pkg::*;
();

    localparam int NUM_LANES     = 4;
    localparam int LW            = NUM_LANES * 64;
    localparam int DIRECTED      = 3 * 4 * 26;      // Variants x widths x ops
    localparam int RANDOM_CYCLES = 400;
    localparam int TIMEOUT_NS    = (16 + DIRECTED + RANDOM_CYCLES + 20) * 100;

    logic          clk;
    logic          rst;
    logic          valid;
    simd_op_t      op;
    sew_t          sew;
    logic [LW-1:0] vs1;
    logic [LW-1:0] vs2;
    logic          out_valid;
    logic [LW-1:0] vd;

    logic [LW-1:0] exp_q[$];                        // Oldest expectation first
    logic [LW-1:0] exp_head;
    logic          exp_avail;
    logic [31:0]   lfsr_state;
    int            errors;
    int            compared;

    simd_exec #(
        .NUM_LANES (NUM_LANES)
    ) u_simd_exec (
        .clk_i   (clk),
        .rst_i   (rst),
        .valid_i (valid),
        .op_i    (op),
        .sew_i   (sew),
        .vs1_i   (vs1),
        .vs2_i   (vs2),
        .valid_o (out_valid),
        .vd_o    (vd)
    );

    bind simd_exec simd_exec_props #(
        .NUM_LANES (NUM_LANES)
    ) u_simd_exec_props (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .valid_out_i (valid_o),
        .vd_out_i    (vd_o)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] width_mask(int w);
        return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    endfunction

    function automatic logic signed [127:0] sign_extend(logic [63:0] v, int w);
        logic signed [127:0] r;
        r = $signed({64'd0, v & width_mask(w)});
        if (v[w-1]) begin
            r = r - (128'sd1 <<< w);
        end
        return r;
    endfunction

    function automatic logic [63:0] replicate(logic [63:0] e, int w);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < 64 / w; i++) begin
            r = r | ((e & width_mask(w)) << (i * w));
        end
        return r;
    endfunction

    // a is the vs1 element and b the vs2 element
    function automatic logic [63:0] element_result(simd_op_t o, int w, logic [63:0] a,
                                                   logic [63:0] b, int idx);
        logic signed [127:0] ua;
        logic signed [127:0] ub;
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic signed [127:0] umax;
        logic signed [127:0] smax;
        logic signed [127:0] smin;
        logic signed [127:0] r;
        int                  sh;
        ua   = $signed({64'd0, a & width_mask(w)});
        ub   = $signed({64'd0, b & width_mask(w)});
        sa   = sign_extend(a, w);
        sb   = sign_extend(b, w);
        umax = $signed({64'd0, width_mask(w)});
        smax = umax >>> 1;
        smin = -smax - 128'sd1;
        sh   = int'(a[5:0]) & (w - 1);
        case (o)
            VADD:    r = ub + ua;
            VSUB:    r = ub - ua;
            VRSUB:   r = ua - ub;
            VSADDU:  r = (ub + ua > umax) ? umax : ub + ua;
            VSSUBU:  r = (ub < ua) ? 128'sd0 : ub - ua;
            VSADD:   r = sb + sa;
            VSSUB:   r = sb - sa;
            VMIN:    r = (sb < sa) ? sb : sa;
            VMINU:   r = (ub < ua) ? ub : ua;
            VMAX:    r = (sb < sa) ? sa : sb;
            VMAXU:   r = (ub < ua) ? ua : ub;
            VMSEQ:   r = (ua == ub) ? umax : 128'sd0;
            VMSNE:   r = (ua != ub) ? umax : 128'sd0;
            VMSLT:   r = (sb < sa) ? umax : 128'sd0;  // vs2 < vs1
            VMSLTU:  r = (ub < ua) ? umax : 128'sd0;
            VSLL:    r = ub << sh;
            VSRL:    r = ub >> sh;
            VSRA:    r = sb >>> sh;
            VMUL:    r = sa * sb;
            VMULH:   r = (sa * sb) >>> w;
            VAND:    r = ua & ub;
            VOR:     r = ua | ub;
            VXOR:    r = ua ^ ub;
            VID:     r = idx;
            VMV:     r = ua;
            default: r = 128'sd0;
        endcase
        if ((o == VSADD || o == VSSUB) && r > smax) begin
            r = smax;
        end
        if ((o == VSADD || o == VSSUB) && r < smin) begin
            r = smin;
        end
        return r[63:0] & width_mask(w);
    endfunction

    function automatic logic [63:0] expected_lane(simd_op_t o, sew_t s, logic [63:0] x,
                                                  logic [63:0] y, int lane);
        int          w;
        logic [63:0] r;
        w = 8 << int'(s);
        r = '0;
        for (int i = 0; i < 64 / w; i++) begin
            r = r | (element_result(o, w, x >> (i * w), y >> (i * w),
                                    lane * (64 / w) + i) << (i * w));
        end
        return r;
    endfunction

    task automatic update_head();
        exp_avail = (exp_q.size() != 0);
        exp_head  = exp_avail ? exp_q[0] : '0;
    endtask

    // Corner operand pairs per element width, pattern 6 is random
    task automatic pick_operands(input int k, input int w,
                                 output logic [63:0] a, output logic [63:0] b);
        logic [63:0] umax;
        logic [63:0] smin;
        logic [63:0] ea;
        logic [63:0] eb;
        umax = width_mask(w);
        smin = (umax >> 1) + 64'd1;
        if (k == 6) begin
            a = rand_bits(64);
            b = rand_bits(64);
        end else begin
            case (k)
                0, 1, 2: ea = 64'd1;
                3:       ea = 64'(w - 1);           // Shift count at the width limit
                4:       ea = umax;
                default: ea = smin;
            endcase
            case (k)
                0:       eb = umax >> 1;            // Signed add overflows
                2:       eb = umax;                 // Unsigned add overflows
                4:       eb = 64'd0;                // Unsigned subtract underflows
                default: eb = smin;
            endcase
            a = replicate(ea, w);
            b = replicate(eb, w);
        end
    endtask

    task automatic drive(input logic v, input simd_op_t o, input sew_t s,
                         input logic [LW-1:0] x, input logic [LW-1:0] y);
        logic [LW-1:0] e;
        @(posedge clk);
        #1;
        valid = v;
        op    = o;
        sew   = s;
        vs1   = x;
        vs2   = y;
        if (v) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                e[l*64 +: 64] = expected_lane(o, s, x[l*64 +: 64], y[l*64 +: 64], l);
            end
            exp_q.push_back(e);
            update_head();
        end
    endtask

    // Outputs settle at the rising edge, retire them mid-cycle
    always @(negedge clk) begin
        if (!rst && out_valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            compared = compared + 1;
            update_head();
        end
    end

    a_result: assert property (@(negedge clk) disable iff (rst)
        out_valid |-> (exp_avail && vd == exp_head))
        else begin
            errors = errors + 1;
            if (!$sampled(exp_avail)) begin
                $display("Result delivered at %0t with no operation outstanding", $time);
            end else begin
                $display("Error at %0t: vd_o expected %h, actual %h",
                         $time, $sampled(exp_head), $sampled(vd));
            end
        end

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns with results still outstanding", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [63:0]   a;
        logic [63:0]   b;
        logic [LW-1:0] x;
        logic [LW-1:0] y;
        clk        = 1'b0;
        rst        = 1'b1;
        valid      = 1'b0;
        op         = VNOP;
        sew        = SEW_8;
        vs1        = '0;
        vs2        = '0;
        lfsr_state = 32'he330_86f7;
        errors     = 0;
        compared   = 0;
        update_head();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) drive(1'b0, VNOP, SEW_8, '0, '0);  // Quiet outputs after reset
        // Directed: ops interleaved, every width, corner and random lanes
        for (int v = 0; v < 3; v++) begin
            for (int s = 0; s < 4; s++) begin
                for (int o = 0; o < 26; o++) begin
                    for (int l = 0; l < NUM_LANES; l++) begin
                        pick_operands((v * NUM_LANES + l) % 7, 8 << s, a, b);
                        x[l*64 +: 64] = a;
                        y[l*64 +: 64] = b;
                    end
                    drive(1'b1, simd_op_t'(5'(o)), sew_t'(2'(s)), x, y);
                end
            end
        end
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                x[l*64 +: 64] = rand_bits(64);
                y[l*64 +: 64] = rand_bits(64);
            end
            drive(rand_bits(2) != 0, simd_op_t'(5'(rand_bits(5) % 26)),
                  sew_t'(2'(rand_bits(2))), x, y);
        end
        drive(1'b0, VNOP, SEW_8, '0, '0);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (MUL_LATENCY) @(posedge clk);
        $display("Run complete: %0d results compared, %0d errors, %0d property failures",
                 compared, errors, u_simd_exec.u_simd_exec_props.fail_count);
        if (errors == 0 && u_simd_exec.u_simd_exec_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- simd_pkg.sv
/* Shared SIMD types: lane word, operation and element-width codes,
   multiplier latency and element mask and sign-extension helpers */
package simd_pkg;

    typedef logic [63:0] lane_t;            // One 64-bit lane

    typedef enum logic [4:0] {
        VADD, VSUB, VRSUB, VSADDU, VSADD, VSSUBU, VSSUB,
        VMIN, VMINU, VMAX, VMAXU, VMSEQ, VMSNE, VMSLT, VMSLTU,
        VSLL, VSRL, VSRA,
        VMUL, VMULH,
        VAND, VOR, VXOR,
        VID, VMV, VNOP
    } simd_op_t;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    localparam int MUL_LATENCY = 2;         // Issue to result, in cycles

    // All-ones in the low w bits of a lane
    function automatic lane_t elem_mask(int w);
        return (w >= 64) ? '1 : ((lane_t'(1) << w) - lane_t'(1));
    endfunction

    // Sign-extend the low w bits of x to a full lane
    function automatic lane_t elem_sext(lane_t x, int w);
        return lane_t'($signed(x << (64 - w)) >>> (64 - w));
    endfunction

endpackage

//--- vaddsub.sv
/* Element-wise add, subtract and reverse subtract with wrap-around,
   plus signed and unsigned saturating add and subtract */
`timescale 1ns/1ps

module vaddsub
    import simd_pkg::*;
(
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  lane_t    vs1_i,
    input  lane_t    vs2_i,
    output lane_t    vd_o
);

    lane_t [3:0] res_all;                   // One result per element width

    // a is the vs1 element, b the vs2 element, both right-aligned
    function automatic lane_t elem_addsub(simd_op_t op, lane_t a, lane_t b, int w);
        logic signed [65:0] ua;
        logic signed [65:0] ub;
        logic signed [65:0] sa;
        logic signed [65:0] sb;
        logic signed [65:0] umax;
        logic signed [65:0] smax;
        logic signed [65:0] smin;
        logic signed [65:0] r;
        logic               sat_s;
        ua    = {2'b00, a & elem_mask(w)};
        ub    = {2'b00, b & elem_mask(w)};
        sa    = 66'($signed(elem_sext(a, w)));
        sb    = 66'($signed(elem_sext(b, w)));
        umax  = {2'b00, elem_mask(w)};
        smax  = {2'b00, elem_mask(w) >> 1};
        smin  = -smax - 66'sd1;
        sat_s = (op == VSADD) || (op == VSSUB);
        case (op)
            VADD:   r = ub + ua;
            VSUB:   r = ub - ua;
            VRSUB:  r = ua - ub;            // vs1 - vs2
            VSADDU: r = (ub + ua > umax) ? umax : ub + ua;
            VSSUBU: r = ub - ua;
            VSADD:  r = sb + sa;
            VSSUB:  r = sb - sa;
            default: r = '0;
        endcase
        if (op == VSSUBU && r[65]) begin
            r = '0;                         // Unsigned underflow floors at zero
        end
        if (sat_s && r > smax) begin
            r = smax;
        end
        if (sat_s && r < smin) begin
            r = smin;
        end
        return r[63:0];
    endfunction

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar i = 0; i < 64 / W; i++) begin : g_elem
            lane_t r;
            assign r = elem_addsub(op_i, lane_t'(vs1_i[i*W +: W]),
                                   lane_t'(vs2_i[i*W +: W]), W);
            assign res_all[s][i*W +: W] = r[W-1:0];
        end
    end

    assign vd_o = res_all[sew_i];

endmodule

//--- vcomp.sv
/* Element-wise min and max, signed and unsigned, and compares that
   return an all-ones or all-zeros element */
`timescale 1ns/1ps

module vcomp
    import simd_pkg::*;
(
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  lane_t    vs1_i,
    input  lane_t    vs2_i,
    output lane_t    vd_o
);

    lane_t [3:0] res_all;

    function automatic lane_t elem_comp(simd_op_t op, lane_t a, lane_t b, int w);
        lane_t              mask;
        lane_t              ua;
        lane_t              ub;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic               lt_s;
        logic               lt_u;
        logic               eq;
        lane_t              r;
        mask = elem_mask(w);
        ua   = a & mask;
        ub   = b & mask;
        sa   = elem_sext(a, w);
        sb   = elem_sext(b, w);
        lt_s = sb < sa;                     // vs2 < vs1
        lt_u = ub < ua;
        eq   = ua == ub;
        case (op)
            VMIN:   r = lt_s ? ub : ua;
            VMINU:  r = lt_u ? ub : ua;
            VMAX:   r = lt_s ? ua : ub;
            VMAXU:  r = lt_u ? ua : ub;
            VMSEQ:  r = eq ? mask : '0;
            VMSNE:  r = eq ? '0 : mask;
            VMSLT:  r = lt_s ? mask : '0;
            VMSLTU: r = lt_u ? mask : '0;
            default: r = '0;
        endcase
        return r;
    endfunction

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar i = 0; i < 64 / W; i++) begin : g_elem
            lane_t r;
            assign r = elem_comp(op_i, lane_t'(vs1_i[i*W +: W]),
                                 lane_t'(vs2_i[i*W +: W]), W);
            assign res_all[s][i*W +: W] = r[W-1:0];
        end
    end

    assign vd_o = res_all[sew_i];

endmodule

//--- vmul.sv
/* Two-stage signed element multiplier: full products in stage 1,
   low or high halves in stage 2 */
`timescale 1ns/1ps

module vmul
    import simd_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  lane_t    vs1_i,
    input  lane_t    vs2_i,
    output lane_t    vd_o
);

    logic [3:0][127:0] prod_all;            // Double-width products per SEW
    logic [127:0]      prod_q;
    sew_t              sew_q;
    logic              high_q;              // VMULH in stage 2
    lane_t [3:0]       half_all;

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar i = 0; i < 64 / W; i++) begin : g_elem
            logic [2*W-1:0] a_ext;
            logic [2*W-1:0] b_ext;
            // Sign-extended operands, so the low 2W bits are the signed product
            assign a_ext = {{W{vs1_i[i*W+W-1]}}, vs1_i[i*W +: W]};
            assign b_ext = {{W{vs2_i[i*W+W-1]}}, vs2_i[i*W +: W]};
            assign prod_all[s][i*2*W +: 2*W] = a_ext * b_ext;
            assign half_all[s][i*W +: W] = high_q ? prod_q[i*2*W+W +: W]
                                                  : prod_q[i*2*W +: W];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prod_q <= '0;
            sew_q  <= SEW_8;
            high_q <= 1'b0;
        end else begin
            prod_q <= prod_all[sew_i];
            sew_q  <= sew_i;
            high_q <= (op_i == VMULH);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vd_o <= '0;
        end else begin
            vd_o <= half_all[sew_q];        // Width travels with the product
        end
    end

endmodule

//--- vshift.sv
/* Element-wise shifts of vs2 by the low bits of each vs1 element:
   left, logical right and arithmetic right */
`timescale 1ns/1ps

module vshift
    import simd_pkg::*;
(
    input  simd_op_t op_i,
    input  sew_t     sew_i,
    input  lane_t    vs1_i,
    input  lane_t    vs2_i,
    output lane_t    vd_o
);

    lane_t [3:0] res_all;

    function automatic lane_t elem_shift(simd_op_t op, lane_t a, lane_t b, int w);
        lane_t              sh;
        logic signed [63:0] sb;
        lane_t              r;
        sh = a & lane_t'(w - 1);            // log2(w) count bits
        sb = elem_sext(b, w);
        case (op)
            VSLL:    r = b << sh;
            VSRL:    r = (b & elem_mask(w)) >> sh;
            VSRA:    r = lane_t'(sb >>> sh);
            default: r = '0;
        endcase
        return r;
    endfunction

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar i = 0; i < 64 / W; i++) begin : g_elem
            lane_t r;
            assign r = elem_shift(op_i, lane_t'(vs1_i[i*W +: W]),
                                  lane_t'(vs2_i[i*W +: W]), W);
            assign res_all[s][i*W +: W] = r[W-1:0];
        end
    end

    assign vd_o = res_all[sew_i];

endmodule
